/* src/vec_defs.svh */
// --------------------------------------------------------------------------
// Size and address constants for the vector execute slice.
// Include this in any file that needs the register geometry or the
// CSR map.
// --------------------------------------------------------------------------
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// One vector register
`define VEC_VLEN 64

// Architectural vector registers, v0 doubles as the mask
`define VEC_NREGS 8

// Integer side width, also the APB data width
`define VEC_XLEN 32

// CSR map on the APB port
`define VEC_ADDR_VTYPE 8'h00
`define VEC_ADDR_VL    8'h04

`endif

/* src/vec_pkg.sv */
// --------------------------------------------------------------------------
// Types shared by the vector unit blocks and the testbench.
// Import with a wildcard inside a module body.
// --------------------------------------------------------------------------
`include "vec_defs.svh"

package vec_pkg;

    typedef enum logic [2:0] {
        VADD  = 3'd0,
        VSUB  = 3'd1,
        VAND  = 3'd2,
        VOR   = 3'd3,
        VXOR  = 3'd4,
        VMIN  = 3'd5,
        VMAX  = 3'd6,
        VMVXS = 3'd7
    } vec_op_e;

    // Code 3 is reserved
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } vec_sew_e;

    typedef struct packed {
        logic       valid;
        vec_op_e    op;
        logic [2:0] vd;
        logic [2:0] vs1;
        logic [2:0] vs2;
        logic       vm;
        logic       use_scalar;
    } vec_instr_t;

    typedef struct packed {
        logic                 valid;
        logic [2:0]           vd;
        logic [`VEC_VLEN-1:0] data;
    } vec_wb_t;

    typedef struct packed {
        logic                 valid;
        logic [`VEC_XLEN-1:0] data;
    } vec_scalar_t;

    typedef struct packed {
        vec_sew_e   sew;
        logic [3:0] vl;
    } vec_cfg_t;

endpackage

/* src/vec_csr.sv */
// --------------------------------------------------------------------------
// APB slave holding vtype and vl for the execute logic.
// No wait states. Bad addresses and reserved widths answer with pslverr.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_csr (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [`VEC_XLEN-1:0] pwdata,
    output logic [`VEC_XLEN-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr,
    output vec_pkg::vec_cfg_t    cfg
);
    import vec_pkg::*;

    logic     access;
    logic     hit_vtype;
    logic     hit_vl;
    logic     sew_bad;
    vec_cfg_t cfg_q;

    assign access    = psel && penable;
    assign hit_vtype = (paddr == `VEC_ADDR_VTYPE);
    assign hit_vl    = (paddr == `VEC_ADDR_VL);
    assign sew_bad   = pwrite && hit_vtype && (pwdata[1:0] == 2'd3);

    assign pready  = 1'b1;
    assign pslverr = access && ((!hit_vtype && !hit_vl) || sew_bad);

    // Update at the access edge, only when the phase is error free
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_q.sew <= SEW8;
            cfg_q.vl  <= 4'd8;
        end else if (access && pwrite && !pslverr) begin
            if (hit_vtype) begin
                cfg_q.sew <= vec_sew_e'(pwdata[1:0]);
            end else begin
                cfg_q.vl <= pwdata[3:0];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (hit_vtype) begin
            prdata[1:0] = cfg_q.sew;
        end else if (hit_vl) begin
            prdata[3:0] = cfg_q.vl;
        end
    end

    assign cfg = cfg_q;

endmodule

/* src/vec_regfile.sv */
// --------------------------------------------------------------------------
// Vector register file, three combinational read ports and one write port.
// v0 is always exported for masking.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [2:0]           rd_addr_a,
    input  logic [2:0]           rd_addr_b,
    input  logic [2:0]           rd_addr_c,
    output logic [`VEC_VLEN-1:0] rd_data_a,
    output logic [`VEC_VLEN-1:0] rd_data_b,
    output logic [`VEC_VLEN-1:0] rd_data_c,
    output logic [`VEC_VLEN-1:0] mask_reg,
    input  logic                 wr_en,
    input  logic [2:0]           wr_addr,
    input  logic [`VEC_VLEN-1:0] wr_data
);

    logic [`VEC_VLEN-1:0] regs [`VEC_NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `VEC_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // No bypass, a write is seen by reads after the edge
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    assign rd_data_c = regs[rd_addr_c];

    assign mask_reg = regs[0];

endmodule

/* src/vec_alu.sv */
// --------------------------------------------------------------------------
// Element-wise ALU over one vector register at 8, 16 or 32 bit elements.
// Purely combinational, carries never cross an element boundary.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_alu (
    input  vec_pkg::vec_op_e     op,
    input  vec_pkg::vec_sew_e    sew,
    input  logic [`VEC_VLEN-1:0] src_a,
    input  logic [`VEC_VLEN-1:0] src_b,
    output logic [`VEC_VLEN-1:0] result
);
    import vec_pkg::*;

    logic [31:0] lane_r;

    // Lanes come in sign-extended, so one routine covers every width
    function automatic logic [31:0] lane_calc(input vec_op_e f,
                                              input logic signed [32:0] a,
                                              input logic signed [32:0] b);
        logic signed [32:0] r;
        case (f)
            VADD:    r = a + b;
            VSUB:    r = a - b;
            VAND:    r = a & b;
            VOR:     r = a | b;
            VXOR:    r = a ^ b;
            VMIN:    r = (a < b) ? a : b;
            VMAX:    r = (a > b) ? a : b;
            default: r = a;
        endcase
        return r[31:0];
    endfunction

    always_comb begin
        result = '0;
        lane_r = '0;
        case (sew)
            SEW8: begin
                for (int i = 0; i < `VEC_VLEN / 8; i++) begin
                    lane_r = lane_calc(op, $signed(src_a[i*8 +: 8]), $signed(src_b[i*8 +: 8]));
                    result[i*8 +: 8] = lane_r[7:0];
                end
            end
            SEW16: begin
                for (int i = 0; i < `VEC_VLEN / 16; i++) begin
                    lane_r = lane_calc(op, $signed(src_a[i*16 +: 16]),
                                       $signed(src_b[i*16 +: 16]));
                    result[i*16 +: 16] = lane_r[15:0];
                end
            end
            default: begin
                for (int i = 0; i < `VEC_VLEN / 32; i++) begin
                    lane_r = lane_calc(op, $signed(src_a[i*32 +: 32]),
                                       $signed(src_b[i*32 +: 32]));
                    result[i*32 +: 32] = lane_r;
                end
            end
        endcase
    end

endmodule

/* src/vec_exec.sv */
// --------------------------------------------------------------------------
// Execute stage: operand select, mask and tail merge, result register.
// Writes the register file at the issue edge, outputs one cycle later.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_exec (
    input  logic                 clk,
    input  logic                 arst_n,
    input  vec_pkg::vec_instr_t  instr,
    input  logic [`VEC_XLEN-1:0] scalar_in,
    input  vec_pkg::vec_cfg_t    cfg,
    output logic [2:0]           rd_addr_a,
    output logic [2:0]           rd_addr_b,
    output logic [2:0]           rd_addr_c,
    input  logic [`VEC_VLEN-1:0] rd_data_a,
    input  logic [`VEC_VLEN-1:0] rd_data_b,
    input  logic [`VEC_VLEN-1:0] rd_data_c,
    input  logic [`VEC_VLEN-1:0] mask_reg,
    output logic                 wr_en,
    output logic [2:0]           wr_addr,
    output logic [`VEC_VLEN-1:0] wr_data,
    output vec_pkg::vec_wb_t     wb,
    output vec_pkg::vec_scalar_t scalar_out
);
    import vec_pkg::*;

    logic [`VEC_VLEN-1:0]   bcast;
    logic [`VEC_VLEN-1:0]   op_b;
    logic [`VEC_VLEN-1:0]   alu_res;
    logic [`VEC_VLEN-1:0]   merged;
    logic [`VEC_VLEN/8-1:0] byte_en;
    logic [1:0]             shift;
    logic [2:0]             idx;
    logic [`VEC_XLEN-1:0]   elem0;

    // vd = vs2 op vs1, vd is read for the merge
    assign rd_addr_a = instr.vs2;
    assign rd_addr_b = instr.vs1;
    assign rd_addr_c = instr.vd;

    always_comb begin
        case (cfg.sew)
            SEW8: begin
                bcast = {(`VEC_VLEN/8){scalar_in[7:0]}};
                shift = 2'd0;
                elem0 = {{24{rd_data_a[7]}}, rd_data_a[7:0]};
            end
            SEW16: begin
                bcast = {(`VEC_VLEN/16){scalar_in[15:0]}};
                shift = 2'd1;
                elem0 = {{16{rd_data_a[15]}}, rd_data_a[15:0]};
            end
            default: begin
                bcast = {(`VEC_VLEN/32){scalar_in[31:0]}};
                shift = 2'd2;
                elem0 = rd_data_a[31:0];
            end
        endcase
    end

    assign op_b = instr.use_scalar ? bcast : rd_data_b;

    vec_alu alu0 (
        .op     (instr.op),
        .sew    (cfg.sew),
        .src_a  (rd_data_a),
        .src_b  (op_b),
        .result (alu_res)
    );

    // Byte granular enables, element index is the byte index scaled down
    always_comb begin
        idx = '0;
        for (int j = 0; j < `VEC_VLEN / 8; j++) begin
            idx = 3'(j) >> shift;
            byte_en[j] = ({1'b0, idx} < cfg.vl) && (instr.vm || mask_reg[idx]);
            merged[j*8 +: 8] = byte_en[j] ? alu_res[j*8 +: 8] : rd_data_c[j*8 +: 8];
        end
    end

    assign wr_en   = instr.valid && (instr.op != VMVXS);
    assign wr_addr = instr.vd;
    assign wr_data = merged;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb         <= '0;
            scalar_out <= '0;
        end else begin
            wb.valid         <= wr_en;
            wb.vd            <= instr.vd;
            wb.data          <= merged;
            scalar_out.valid <= instr.valid && (instr.op == VMVXS);
            scalar_out.data  <= elem0;
        end
    end

endmodule

/* src/vec_unit.sv */
// --------------------------------------------------------------------------
// Top of the vector execute slice: CSR block, register file and execute.
// Decoded instructions in, vector writeback and scalar results out.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [`VEC_XLEN-1:0] pwdata,
    output logic [`VEC_XLEN-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  vec_pkg::vec_instr_t  instr,
    input  logic [`VEC_XLEN-1:0] scalar_in,
    output vec_pkg::vec_wb_t     wb,
    output vec_pkg::vec_scalar_t scalar_out
);
    import vec_pkg::*;

    vec_cfg_t             cfg;
    logic [2:0]           rd_addr_a;
    logic [2:0]           rd_addr_b;
    logic [2:0]           rd_addr_c;
    logic [`VEC_VLEN-1:0] rd_data_a;
    logic [`VEC_VLEN-1:0] rd_data_b;
    logic [`VEC_VLEN-1:0] rd_data_c;
    logic [`VEC_VLEN-1:0] mask_reg;
    logic                 wr_en;
    logic [2:0]           wr_addr;
    logic [`VEC_VLEN-1:0] wr_data;

    vec_csr csr0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg)
    );

    vec_regfile rf0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_addr_c (rd_addr_c),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rd_data_c (rd_data_c),
        .mask_reg  (mask_reg),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    vec_exec exec0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .scalar_in  (scalar_in),
        .cfg        (cfg),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_addr_c  (rd_addr_c),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .rd_data_c  (rd_data_c),
        .mask_reg   (mask_reg),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wb         (wb),
        .scalar_out (scalar_out)
    );

endmodule

/* bench/vec_unit_properties.sv */
// --------------------------------------------------------------------------
// Concurrent checks on the vector unit, attached to every vec_unit by bind.
// Covers result latency, APB error timing and output exclusivity.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module vec_unit_properties (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 psel,
    input logic                 penable,
    input logic                 pslverr,
    input vec_pkg::vec_cfg_t    cfg,
    input vec_pkg::vec_instr_t  instr,
    input vec_pkg::vec_wb_t     wb,
    input vec_pkg::vec_scalar_t scalar_out
);

    logic out_valid;

    assign out_valid = wb.valid || scalar_out.valid;

    // Exactly one cycle from issue to result
    issue_gives_result: assert property (@(posedge clk) disable iff (!arst_n)
        instr.valid |=> out_valid)
        else $error("no result one cycle after a valid instruction");

    result_needs_issue: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(instr.valid))
        else $error("result without a valid instruction one cycle earlier");

    // An error phase is an access phase and leaves vtype and vl alone
    err_in_access_no_update: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> (psel && penable) ##1 $stable(cfg))
        else $error("pslverr outside an access phase, or CSR state changed on an error");

    one_output_at_a_time: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb.valid && scalar_out.valid))
        else $error("vector and scalar results valid together");

endmodule

bind vec_unit vec_unit_properties props0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pslverr    (pslverr),
    .cfg        (cfg),
    .instr      (instr),
    .wb         (wb),
    .scalar_out (scalar_out)
);

/* bench/vec_unit_tb.sv */
// --------------------------------------------------------------------------
// Directed-random testbench for the vector unit. Drives APB and decoded
// instructions, predicts every result from its own register model.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vec_defs.svh"

module vec_unit_tb;
    import vec_pkg::*;

    localparam int CSR_ROUNDS = 10;
    localparam int VV_PER_SEW = 50;
    localparam int SC_PER_SEW = 20;
    localparam int TM_PER_SEW = 40;
    localparam int MV_PER_SEW = 10;
    localparam int CHAINS     = 10;
    localparam int CHAIN_LEN  = 6;
    localparam int N_INSTR    = 16 + 3 * (VV_PER_SEW + SC_PER_SEW + TM_PER_SEW + MV_PER_SEW)
                                + CHAINS * CHAIN_LEN;
    localparam int N_APB      = 2 + 10 * CSR_ROUNDS + 3 + 3 * (2 + 2 + 1 + TM_PER_SEW + 2)
                                + 2 * CHAINS;
    localparam int CYCLE_LIMIT = (N_INSTR + N_APB) * 2 + 100;

    logic                 clk;
    logic                 arst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [7:0]           paddr;
    logic [`VEC_XLEN-1:0] pwdata;
    logic [`VEC_XLEN-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
    vec_instr_t           instr;
    logic [`VEC_XLEN-1:0] scalar_in;
    vec_wb_t              wb;
    vec_scalar_t          scalar_out;

    // Reference state
    logic [`VEC_VLEN-1:0] m_regs [`VEC_NREGS];
    vec_sew_e             m_sew;
    logic [3:0]           m_vl;
    integer               seed;
    int                   cycles = 0;

    vec_unit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_error("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_wb(input string name, input vec_wb_t exp, input vec_wb_t act);
        if (act.valid !== exp.valid ||
            (exp.valid && (act.vd !== exp.vd || act.data !== exp.data))) begin
            stop_with_error($sformatf(
                "MISMATCH %s: wb expected valid=%b vd=%0d data=%h, actual valid=%b vd=%0d data=%h",
                name, exp.valid, exp.vd, exp.data, act.valid, act.vd, act.data));
        end
    endtask

    task automatic check_scalar(input string name, input vec_scalar_t exp,
                                input vec_scalar_t act);
        if (act.valid !== exp.valid || (exp.valid && act.data !== exp.data)) begin
            stop_with_error($sformatf(
                "MISMATCH %s: scalar expected valid=%b data=%h, actual valid=%b data=%h",
                name, exp.valid, exp.data, act.valid, act.data));
        end
    endtask

    task automatic check_apb(input string name, input logic is_read,
                             input logic [`VEC_XLEN-1:0] exp_rd, input logic exp_err,
                             input logic [`VEC_XLEN-1:0] act_rd, input logic act_err);
        if (act_err !== exp_err) begin
            stop_with_error($sformatf("MISMATCH %s: pslverr expected %b, actual %b",
                                      name, exp_err, act_err));
        end
        if (is_read && !exp_err && act_rd !== exp_rd) begin
            stop_with_error($sformatf("MISMATCH %s: prdata expected %h, actual %h",
                                      name, exp_rd, act_rd));
        end
    endtask

    // One APB transfer, called 1 ns after a rising edge
    task automatic apb_access(input string name, input logic wr, input logic [7:0] addr,
                              input logic [`VEC_XLEN-1:0] data);
        logic                 exp_err;
        logic [`VEC_XLEN-1:0] exp_rd;
        logic [`VEC_XLEN-1:0] rd;
        logic                 err;
        exp_err = !(addr == `VEC_ADDR_VTYPE || addr == `VEC_ADDR_VL) ||
                  (wr && addr == `VEC_ADDR_VTYPE && data[1:0] == 2'd3);
        exp_rd  = (addr == `VEC_ADDR_VTYPE) ? {30'd0, m_sew} : {28'd0, m_vl};
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rd  = prdata;
        err = pslverr;
        if (pready !== 1'b1) begin
            stop_with_error({name, ": pready was low during the access phase"});
        end
        check_apb(name, !wr, exp_rd, exp_err, rd, err);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (wr && !exp_err) begin
            if (addr == `VEC_ADDR_VTYPE) begin
                m_sew = vec_sew_e'(data[1:0]);
            end else begin
                m_vl = data[3:0];
            end
        end
    endtask

    task automatic set_cfg(input string name, input int sew, input int vl);
        apb_access(name, 1'b1, `VEC_ADDR_VTYPE, 32'(sew));
        apb_access(name, 1'b1, `VEC_ADDR_VL, 32'(vl));
    endtask

    // Signed compare on the low ew bits of each operand
    function automatic logic [31:0] lane_ref(input vec_op_e op, input logic [31:0] a,
                                             input logic [31:0] b, input int ew);
        int          sa;
        int          sb;
        logic [31:0] r;
        sa = $signed(a << (32 - ew)) >>> (32 - ew);
        sb = $signed(b << (32 - ew)) >>> (32 - ew);
        case (op)
            VADD:    r = a + b;
            VSUB:    r = a - b;
            VAND:    r = a & b;
            VOR:     r = a | b;
            VXOR:    r = a ^ b;
            VMIN:    r = (sa < sb) ? a : b;
            VMAX:    r = (sa > sb) ? a : b;
            default: r = a;
        endcase
        return r;
    endfunction

    task automatic predict(input vec_instr_t ins, input logic [31:0] sc,
                           output vec_wb_t exp_wb, output vec_scalar_t exp_sc);
        int          ew;
        logic [31:0] lm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [63:0] res;
        ew  = 8 << m_sew;
        lm  = (ew == 32) ? 32'hffff_ffff : (32'd1 << ew) - 32'd1;
        res = m_regs[ins.vd];
        for (int i = 0; i < `VEC_VLEN / ew; i++) begin
            a = 32'(m_regs[ins.vs2] >> (i * ew)) & lm;
            b = ins.use_scalar ? (sc & lm) : (32'(m_regs[ins.vs1] >> (i * ew)) & lm);
            if (i < m_vl && (ins.vm || m_regs[0][i])) begin
                r   = lane_ref(ins.op, a, b, ew) & lm;
                res = (res & ~(64'(lm) << (i * ew))) | (64'(r) << (i * ew));
            end
        end
        exp_wb.valid = (ins.op != VMVXS);
        exp_wb.vd    = ins.vd;
        exp_wb.data  = res;
        exp_sc.valid = (ins.op == VMVXS);
        exp_sc.data  = $signed(32'(m_regs[ins.vs2]) << (32 - ew)) >>> (32 - ew);
    endtask

    // Drive one instruction and check its result one cycle later
    task automatic issue(input string name, input vec_instr_t ins, input logic [31:0] sc);
        vec_wb_t     exp_wb;
        vec_scalar_t exp_sc;
        predict(ins, sc, exp_wb, exp_sc);
        instr     = ins;
        scalar_in = sc;
        @(posedge clk);
        #1;
        instr = '0;
        check_wb(name, exp_wb, wb);
        check_scalar(name, exp_sc, scalar_out);
        if (exp_wb.valid) begin
            m_regs[exp_wb.vd] = exp_wb.data;
        end
    endtask

    function automatic vec_op_e rand_alu_op();
        int unsigned r;
        r = $random(seed);
        return vec_op_e'(3'(r % 7));
    endfunction

    function automatic vec_instr_t rand_instr(input vec_op_e op, input logic vm,
                                              input logic use_sc);
        vec_instr_t ins;
        ins.valid      = 1'b1;
        ins.op         = op;
        ins.vd         = 3'($random(seed));
        ins.vs1        = 3'($random(seed));
        ins.vs2        = 3'($random(seed));
        ins.vm         = vm;
        ins.use_scalar = use_sc;
        return ins;
    endfunction

    initial begin
        vec_instr_t ins;
        logic [2:0] prev;
        logic [7:0] bad;
        int         w;
        seed      = 32'hc7f91847;
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        instr     = '0;
        scalar_in = '0;
        m_sew     = SEW8;
        m_vl      = 4'd8;
        for (int i = 0; i < `VEC_NREGS; i++) begin
            m_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        apb_access("reset_vtype", 1'b0, `VEC_ADDR_VTYPE, '0);
        apb_access("reset_vl", 1'b0, `VEC_ADDR_VL, '0);
        for (int r = 0; r < CSR_ROUNDS; r++) begin
            apb_access("csr_vtype", 1'b1, `VEC_ADDR_VTYPE, $unsigned($random(seed)) % 3);
            apb_access("csr_vtype", 1'b0, `VEC_ADDR_VTYPE, '0);
            apb_access("csr_vl", 1'b1, `VEC_ADDR_VL, $random(seed));
            apb_access("csr_vl", 1'b0, `VEC_ADDR_VL, '0);
            apb_access("csr_bad_sew", 1'b1, `VEC_ADDR_VTYPE, $random(seed) | 3);
            apb_access("csr_bad_sew", 1'b0, `VEC_ADDR_VTYPE, '0);
            bad = 8'($random(seed)) | 8'h10;
            apb_access("csr_bad_addr", 1'b1, bad, $random(seed));
            apb_access("csr_bad_addr", 1'b0, bad, '0);
            // Both registers must survive the rejected writes
            apb_access("csr_keep_vtype", 1'b0, `VEC_ADDR_VTYPE, '0);
            apb_access("csr_keep_vl", 1'b0, `VEC_ADDR_VL, '0);
        end

        // Give every register distinct elements before the ALU tests
        set_cfg("fill", 2, 1);
        for (int i = 0; i < `VEC_NREGS; i++) begin
            ins = '{1'b1, VADD, 3'(i), 3'(i), 3'(i), 1'b1, 1'b1};
            issue("fill_add", ins, $random(seed));
        end
        apb_access("fill", 1'b1, `VEC_ADDR_VL, 32'd2);
        for (int i = 0; i < `VEC_NREGS; i++) begin
            ins = '{1'b1, VXOR, 3'(i), 3'(i), 3'(i), 1'b1, 1'b1};
            issue("fill_xor", ins, $random(seed));
        end

        for (w = 0; w < 3; w++) begin
            set_cfg("vv", w, 8 >> w);
            for (int k = 0; k < VV_PER_SEW; k++) begin
                issue($sformatf("vv_sew%0d", 8 << w), rand_instr(rand_alu_op(), 1'b1, 1'b0),
                      $random(seed));
            end
        end

        for (w = 0; w < 3; w++) begin
            set_cfg("scalar", w, 8 >> w);
            for (int k = 0; k < SC_PER_SEW; k++) begin
                issue($sformatf("scalar_sew%0d", 8 << w), rand_instr(rand_alu_op(), 1'b1, 1'b1),
                      $random(seed));
            end
        end

        for (w = 0; w < 3; w++) begin
            apb_access("tail_mask", 1'b1, `VEC_ADDR_VTYPE, 32'(w));
            for (int k = 0; k < TM_PER_SEW; k++) begin
                apb_access("tail_mask", 1'b1, `VEC_ADDR_VL, $unsigned($random(seed)) % 9);
                ins = rand_instr(rand_alu_op(), 1'($random(seed)), 1'($random(seed)));
                issue($sformatf("tail_mask_sew%0d", 8 << w), ins, $random(seed));
            end
        end

        // vl of 0 on the first width
        for (w = 0; w < 3; w++) begin
            set_cfg("move", w, w * 3);
            for (int k = 0; k < MV_PER_SEW; k++) begin
                ins = rand_instr(VMVXS, 1'($random(seed)), 1'b0);
                issue($sformatf("move_sew%0d", 8 << w), ins, $random(seed));
            end
        end

        for (int c = 0; c < CHAINS; c++) begin
            w = c % 3;
            set_cfg("chain", w, 8 >> w);
            ins = rand_instr(rand_alu_op(), 1'b1, 1'b0);
            for (int k = 0; k < CHAIN_LEN; k++) begin
                issue($sformatf("chain%0d_step%0d", c, k), ins, $random(seed));
                prev    = ins.vd;
                ins     = rand_instr(rand_alu_op(), 1'b1, 1'b0);
                ins.vs2 = prev;
                if (k % 2 == 1) begin
                    ins.vs1 = prev;
                end
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
src/vec_pkg.sv
src/vec_csr.sv
src/vec_regfile.sv
src/vec_alu.sv
src/vec_exec.sv
src/vec_unit.sv
bench/vec_unit_properties.sv
bench/vec_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the vector unit testbench with Verilator, run it, and check the log.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module vec_unit_tb -o vec_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vec_unit_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Errors found" "$log"; then
    echo "Simulation reported failures"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation passed"
exit 0
